/* design/xadc_params.svh */
`ifndef XADC_PARAMS_SVH
`define XADC_PARAMS_SVH

// Conversion port
`define XADC_RESULT_W         12
`define XADC_CHAN_W           3
`define XADC_CODE_W           4     // Codes above 7 select all channels

// Packet geometry
`define XADC_SAMPLES_PER_PKT  5
`define XADC_WORDS_PER_PKT    4
`define XADC_WORD_W           16
`define XADC_PKT_W            64

// Frame and run control
`define XADC_MAX_FRAME_WORDS  600   // Words per frame before a forced end
`define XADC_LEN_W            12
`define XADC_COUNT_W          11
`define XADC_DELAY_W          18

`endif

/* design/xadc_pkg.sv */
`include "xadc_params.svh"

package xadc_pkg;

    // Header nibble on top, slot 4 just below it, slot 0 at the bottom
    typedef struct packed {
        logic [`XADC_PKT_W-`XADC_SAMPLES_PER_PKT*`XADC_RESULT_W-1:0] header;
        logic [`XADC_SAMPLES_PER_PKT-1:0][`XADC_RESULT_W-1:0]       slot;
    } pkt_fields_t;

    // Same 64 bits seen by the assembler as fields, by the writer as FIFO words
    typedef union packed {
        pkt_fields_t                                       fields;
        logic [`XADC_WORDS_PER_PKT-1:0][`XADC_WORD_W-1:0]  words;  // Word 3 goes out first
    } xadc_packet_u;

endpackage

/* design/sample_sequencer.sv */
`timescale 1ns/1ps
`include "xadc_params.svh"

module sample_sequencer
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        data_in_rdy,
    input  logic [`XADC_CODE_W-1:0]     chan_code,
    input  logic [`XADC_COUNT_W-1:0]    sample_size,
    input  logic                        conv_done,
    input  logic [`XADC_RESULT_W-1:0]   conv_result,
    input  logic                        delay_expired,
    input  logic                        frame_done,
    output logic                        busy,
    output logic                        conv_start,
    output logic [`XADC_CHAN_W-1:0]     chan_sel,
    output logic                        delay_load,
    output logic                        sample_save,
    output logic [`XADC_RESULT_W-1:0]   sample_value,
    output logic [`XADC_CHAN_W-1:0]     sample_chan,
    output logic                        flush
);

typedef enum logic [2:0] {
    st_idle,
    st_convert,
    st_wait_conv,
    st_gap,
    st_flush_wait,
    st_release
} seq_state_t;

seq_state_t                 state;
logic                       all_chan;    // Sweep channels 0..7
logic [`XADC_COUNT_W-1:0]   sample_cnt;  // Conversions done on this channel
logic [1:0]                 flush_dly;   // Holds flush back behind the last save

//////////////////////////////
// Run control
//////////////////////////////
always_ff @(posedge clk125)
begin
    if (rst)
    begin
        state       <= st_idle;
        busy        <= 1'b0;
        conv_start  <= 1'b0;
        delay_load  <= 1'b0;
        sample_save <= 1'b0;
        flush       <= 1'b0;
        flush_dly   <= 2'b00;
        all_chan    <= 1'b0;
        chan_sel    <= '0;
        sample_cnt  <= '0;
    end
    else
    begin
        conv_start  <= 1'b0;                   // Pulses by default
        delay_load  <= 1'b0;
        sample_save <= 1'b0;
        flush_dly   <= {flush_dly[0], 1'b0};
        flush       <= flush_dly[1];           // Two cycles after the last save
        case (state)
            st_idle:
            begin
                if (data_in_rdy)
                begin
                    busy       <= 1'b1;
                    all_chan   <= (chan_code > `XADC_CODE_W'(7));
                    chan_sel   <= (chan_code > `XADC_CODE_W'(7)) ?
                                  '0 : chan_code[`XADC_CHAN_W-1:0];
                    sample_cnt <= '0;
                    state      <= st_convert;
                end
            end
            st_convert:
            begin
                conv_start <= 1'b1;            // chan_sel already settled
                state      <= st_wait_conv;
            end
            st_wait_conv:
            begin
                if (conv_done)
                begin
                    sample_save <= 1'b1;
                    sample_cnt  <= sample_cnt + `XADC_COUNT_W'(1);
                    if (sample_cnt + `XADC_COUNT_W'(1) == sample_size)
                    begin
                        flush_dly <= 2'b01;    // Channel finished
                        state     <= st_flush_wait;
                    end
                    else
                    begin
                        delay_load <= 1'b1;
                        state      <= st_gap;
                    end
                end
            end
            st_gap:
            begin
                if (delay_expired)
                    state <= st_convert;
            end
            st_flush_wait:
            begin
                if (frame_done)
                begin
                    sample_cnt <= '0;
                    // Next channel of the sweep, or done
                    if (all_chan && chan_sel != '1)
                    begin
                        chan_sel <= chan_sel + `XADC_CHAN_W'(1);
                        state    <= st_convert;
                    end
                    else
                        state <= st_release;
                end
            end
            st_release:
            begin
                if (!data_in_rdy)              // Old request withdrawn
                begin
                    busy  <= 1'b0;
                    state <= st_idle;
                end
            end
            default: state <= st_idle;
        endcase
    end
end

// Result and its channel one cycle behind conv_done
always_ff @(posedge clk125)
begin
    if (conv_done)
    begin
        sample_value <= conv_result;
        sample_chan  <= chan_sel;
    end
end

a_start_apart_from_done: assert property (@(posedge clk125) disable iff (rst)
    conv_start |-> !conv_done);

a_done_then_save: assert property (@(posedge clk125) disable iff (rst)
    conv_done |=> sample_save);

endmodule

/* design/sample_delay_timer.sv */
`timescale 1ns/1ps
`include "xadc_params.svh"

module sample_delay_timer
(
    input  logic                       clk125,
    input  logic                       rst,
    input  logic                       delay_load,
    input  logic [`XADC_DELAY_W-1:0]   delay_in,
    output logic                       delay_expired
);

logic [`XADC_DELAY_W-1:0]   count;    // Cycles left in the gap
logic                       running;

// Fires delay_in+1 cycles after the load pulse
assign delay_expired = running && (count == '0);

always_ff @(posedge clk125)
begin
    if (rst)
    begin
        running <= 1'b0;
        count   <= '0;
    end
    else if (delay_load && !running)
    begin
        running <= 1'b1;
        count   <= delay_in;
    end
    else if (running)
    begin
        if (count == '0)
            running <= 1'b0;               // Expiry cycle
        else
            count <= count - `XADC_DELAY_W'(1);
    end
end

a_no_reload: assert property (@(posedge clk125) disable iff (rst)
    delay_load |-> !running);

endmodule

/* design/packet_assembler.sv */
`timescale 1ns/1ps
`include "xadc_params.svh"

module packet_assembler
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        sample_save,
    input  logic [`XADC_RESULT_W-1:0]   sample_value,
    input  logic [`XADC_CHAN_W-1:0]     sample_chan,
    input  logic                        flush,
    output logic                        pkt_ready,
    output xadc_pkg::xadc_packet_u      pkt_data,
    output logic                        pkt_empty_flush
);

xadc_pkg::xadc_packet_u   pkt;         // Packet being filled
xadc_pkg::xadc_packet_u   pkt_next;    // pkt with the incoming result merged
logic [2:0]               fill;        // Slots in use
logic                     pkt_full;    // Fifth result arriving
logic                     flush_send;  // Flush of a partial packet

assign pkt_full   = sample_save && (fill == 3'(`XADC_SAMPLES_PER_PKT - 1));
assign flush_send = flush && (fill != 3'd0);

// Slot picked by the fill count and header taken from the channel
always_comb
begin
    pkt_next                   = pkt;
    pkt_next.fields.header     = {1'b0, sample_chan};
    pkt_next.fields.slot[fill] = sample_value;
end

//////////////////////////////
// Fill and handover
//////////////////////////////
always_ff @(posedge clk125)
begin
    if (rst)
    begin
        pkt             <= '0;
        fill            <= 3'd0;
        pkt_ready       <= 1'b0;
        pkt_empty_flush <= 1'b0;
    end
    else
    begin
        pkt_ready       <= pkt_full || flush_send;
        pkt_empty_flush <= flush && (fill == 3'd0);   // Nothing left to send
        if (pkt_full || flush_send)
        begin
            pkt  <= '0;                    // Cleared as it leaves
            fill <= 3'd0;
        end
        else if (sample_save)
        begin
            pkt  <= pkt_next;
            fill <= fill + 3'd1;
        end
    end
end

// Copy handed to the writer
always_ff @(posedge clk125)
begin
    if (pkt_full)
        pkt_data <= pkt_next;
    else if (flush_send)
        pkt_data <= pkt;
end

a_flush_apart_from_save: assert property (@(posedge clk125) disable iff (rst)
    flush |-> !sample_save);

endmodule

/* design/fifo_writer.sv */
`timescale 1ns/1ps
`include "xadc_params.svh"

module fifo_writer
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        pkt_ready,
    input  xadc_pkg::xadc_packet_u      pkt_data,
    input  logic                        pkt_empty_flush,
    input  logic                        flush,
    output logic                        fifo_wr,
    output logic [`XADC_WORD_W-1:0]     fifo_data,
    output logic                        end_of_data,
    output logic [`XADC_LEN_W-1:0]      packet_len,
    output logic                        frame_done
);

xadc_pkg::xadc_packet_u   snap;         // Packet being drained
logic                     sending;      // Words 2..0 still to go
logic [1:0]               word_idx;     // Next snapshot word
logic                     flush_flag;   // Flush not yet matched to a packet
logic                     snap_flush;   // Snapshot closes its frame
logic                     empty_pend;   // Empty flush held behind the stream
logic [`XADC_LEN_W-1:0]   frame_words;  // Words in this frame so far
logic                     frame_end;

assign frame_end = snap_flush ||
                   (frame_words >= `XADC_LEN_W'(`XADC_MAX_FRAME_WORDS));

//////////////////////////////
// Word sequencing and framing
//////////////////////////////
always_ff @(posedge clk125)
begin
    if (rst)
    begin
        sending     <= 1'b0;
        word_idx    <= 2'd0;
        flush_flag  <= 1'b0;
        snap_flush  <= 1'b0;
        empty_pend  <= 1'b0;
        frame_words <= '0;
        fifo_wr     <= 1'b0;
        end_of_data <= 1'b0;
        packet_len  <= '0;
        frame_done  <= 1'b0;
    end
    else
    begin
        fifo_wr     <= 1'b0;
        end_of_data <= 1'b0;
        frame_done  <= fifo_wr && end_of_data && snap_flush;  // After a flush's word 0
        if (flush)
            flush_flag <= 1'b1;
        if (pkt_ready)
        begin
            snap_flush  <= flush_flag;
            flush_flag  <= 1'b0;
            sending     <= 1'b1;
            word_idx    <= 2'(`XADC_WORDS_PER_PKT - 2);      // Word 3 leaves now
            fifo_wr     <= 1'b1;
            frame_words <= frame_words + `XADC_LEN_W'(`XADC_WORDS_PER_PKT);
        end
        else if (sending)
        begin
            fifo_wr  <= 1'b1;
            word_idx <= word_idx - 2'd1;
            if (word_idx == 2'd0)
            begin
                sending <= 1'b0;
                if (frame_end)             // Mark on word 0
                begin
                    end_of_data <= 1'b1;
                    packet_len  <= frame_words;
                    frame_words <= '0;
                end
            end
        end
        else if (pkt_empty_flush || empty_pend)
        begin
            end_of_data <= 1'b1;           // Marker without a write
            frame_done  <= 1'b1;
            packet_len  <= frame_words;
            frame_words <= '0;
            empty_pend  <= 1'b0;
            flush_flag  <= 1'b0;
        end
        if (pkt_empty_flush && sending)
        begin
            empty_pend <= 1'b1;            // Wait for the stream to finish
            flush_flag <= 1'b0;
        end
    end
end

// Snapshot and output word
always_ff @(posedge clk125)
begin
    if (pkt_ready)
    begin
        snap      <= pkt_data;
        fifo_data <= pkt_data.words[`XADC_WORDS_PER_PKT-1];
    end
    else if (sending)
        fifo_data <= snap.words[word_idx];
end

a_no_overrun: assert property (@(posedge clk125) disable iff (rst)
    pkt_ready |-> !sending);

endmodule

/* design/xadc_sampler_top.sv */
`timescale 1ns/1ps
`include "xadc_params.svh"

module xadc_sampler_top
(
    input  logic                        clk125,
    input  logic                        rst,
    input  logic                        data_in_rdy,
    input  logic [`XADC_CODE_W-1:0]     chan_code,
    input  logic [`XADC_COUNT_W-1:0]    sample_size,
    input  logic [`XADC_DELAY_W-1:0]    delay_in,
    input  logic                        conv_done,
    input  logic [`XADC_RESULT_W-1:0]   conv_result,
    output logic                        busy,
    output logic                        conv_start,
    output logic [`XADC_CHAN_W-1:0]     chan_sel,
    output logic                        fifo_wr,
    output logic [`XADC_WORD_W-1:0]     fifo_data,
    output logic                        end_of_data,
    output logic [`XADC_LEN_W-1:0]      packet_len
);

// Sequencer to timer
logic                        delay_load;
logic                        delay_expired;

// Sequencer to assembler
logic                        sample_save;
logic [`XADC_RESULT_W-1:0]   sample_value;
logic [`XADC_CHAN_W-1:0]     sample_chan;
logic                        flush;

// Assembler to writer, writer back to sequencer
logic                        pkt_ready;
xadc_pkg::xadc_packet_u      pkt_data;
logic                        pkt_empty_flush;
logic                        frame_done;

// Port names match the wires above one for one
sample_sequencer   u_sequencer (.*);
sample_delay_timer u_timer     (.*);
packet_assembler   u_assembler (.*);
fifo_writer        u_writer    (.*);

endmodule

/* test/tb_xadc_sampler.sv */
`timescale 1ns/1ps
`include "xadc_params.svh"

module tb_xadc_sampler;

// Run table: channel code, samples per channel, gap cycles
int test_code[$] = '{5, 2, 15, 6};
int test_size[$] = '{10, 7, 5, 800};
int test_gap[$]  = '{3, 2, 1, 0};

logic                        clk125 = 1'b0;
logic                        rst;
logic                        data_in_rdy;
logic [`XADC_CODE_W-1:0]     chan_code;
logic [`XADC_COUNT_W-1:0]    sample_size;
logic [`XADC_DELAY_W-1:0]    delay_in;
logic                        conv_done = 1'b0;
logic [`XADC_RESULT_W-1:0]   conv_result = '0;
logic                        busy;
logic                        conv_start;
logic [`XADC_CHAN_W-1:0]     chan_sel;
logic                        fifo_wr;
logic [`XADC_WORD_W-1:0]     fifo_data;
logic                        end_of_data;
logic [`XADC_LEN_W-1:0]      packet_len;

// ADC model
logic [16:0]                 lfsr = 17'd75063;
logic [15:0]                 adc_bits;
int                          adc_wait = 0;     // Cycles left in this conversion
logic [`XADC_CHAN_W-1:0]     adc_chan;
logic [`XADC_RESULT_W-1:0]   res_val[$];       // Conversion log
logic [`XADC_CHAN_W-1:0]     res_chan[$];

// Run setup, owned by the main process
int                          run_size = 0;
int                          n_chans = 1;
int                          run_base = 0;
logic [`XADC_CODE_W-1:0]     run_code = '0;

// Checker state, events are {wr, eod, len[11:0], word[15:0]}
logic [29:0]                 exp_q[$];
logic [29:0]                 act_q[$];
time                         act_t[$];
int                          res_used = 0;     // Log entries already turned into events
int                          chans_built = 0;
int                          ref_words = 0;    // Reference frame word count
int                          eod_expected = 0;
int                          eod_seen = 0;
logic [`XADC_CHAN_W-1:0]     cur_chan;
int                          chk_idx;
int                          data_errs = 0;
int                          hs_errs = 0;
int                          run_errs = 0;

xadc_sampler_top DUT
(
    .clk125      (clk125),
    .rst         (rst),
    .data_in_rdy (data_in_rdy),
    .chan_code   (chan_code),
    .sample_size (sample_size),
    .delay_in    (delay_in),
    .conv_done   (conv_done),
    .conv_result (conv_result),
    .busy        (busy),
    .conv_start  (conv_start),
    .chan_sel    (chan_sel),
    .fifo_wr     (fifo_wr),
    .fifo_data   (fifo_data),
    .end_of_data (end_of_data),
    .packet_len  (packet_len)
);

always #4 clk125 = ~clk125;                    // 125 MHz

// x^17 + x^14 + 1, new bit enters at the bottom
function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    lfsr_next = {s[15:0], s[16] ^ s[13]};
endfunction

task automatic draw_bits(input int n, output logic [15:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
        lfsr = lfsr_next(lfsr);                // One step per bit
        v    = {v[14:0], lfsr[0]};
    end
endtask

//////////////////////////////
// ADC model
//////////////////////////////
always @(posedge clk125)
begin
    conv_done <= 1'b0;
    if (!rst && conv_start)
    begin
        draw_bits(3, adc_bits);
        adc_wait = int'(adc_bits[2:0]) + 1;    // 1 to 8 cycles
        adc_chan = chan_sel;
    end
    else if (adc_wait > 0)
    begin
        adc_wait--;
        if (adc_wait == 0)
        begin
            draw_bits(`XADC_RESULT_W, adc_bits);
            conv_done   <= 1'b1;
            conv_result <= adc_bits[`XADC_RESULT_W-1:0];
            res_val.push_back(adc_bits[`XADC_RESULT_W-1:0]);
            res_chan.push_back(adc_chan);
        end
    end
end

// Expected FIFO stream for one channel's results
function automatic void build_expected(input int first, input int count,
                                       input logic [`XADC_CHAN_W-1:0] chan);
    xadc_pkg::xadc_packet_u pkt;
    int                     n;
    int                     i;
    int                     w;
    int                     taken;
    logic                   eod;
    taken = 0;
    eod   = 1'b0;
    while (taken < count)
    begin
        n = (count - taken < `XADC_SAMPLES_PER_PKT) ? count - taken : `XADC_SAMPLES_PER_PKT;
        pkt               = '0;                // Unused slots stay zero
        pkt.fields.header = {1'b0, chan};
        for (i = 0; i < n; i++)
            pkt.fields.slot[3'(i)] = res_val[first + taken + i];   // Slot 0 first
        taken     = taken + n;
        ref_words = ref_words + `XADC_WORDS_PER_PKT;
        for (w = `XADC_WORDS_PER_PKT - 1; w >= 0; w--)
        begin
            // Frame ends on a partial flush or at the word limit
            eod = (w == 0) && ((taken == count && n < `XADC_SAMPLES_PER_PKT) ||
                               ref_words >= `XADC_MAX_FRAME_WORDS);
            exp_q.push_back({1'b1, eod, eod ? 12'(ref_words) : 12'd0, pkt.words[2'(w)]});
        end
        if (eod)
        begin
            ref_words = 0;
            eod_expected++;
        end
    end
    if (count % `XADC_SAMPLES_PER_PKT == 0)
    begin
        exp_q.push_back({1'b0, 1'b1, 12'(ref_words), 16'd0});   // Empty flush marker
        ref_words = 0;
        eod_expected++;
    end
endfunction

task automatic compare_event(input logic [29:0] got, input logic [29:0] want, input time t);
    assert (got[29] == want[29]) else
    begin
        data_errs++;
        $display("FAIL t=%0t fifo_wr expected %b got %b", t, want[29], got[29]);
    end
    if (got[29] && want[29])
    begin
        assert (got[15:0] == want[15:0]) else
        begin
            data_errs++;
            $display("FAIL t=%0t fifo_data expected %h got %h", t, want[15:0], got[15:0]);
        end
    end
    assert (got[28] == want[28]) else
    begin
        data_errs++;
        $display("FAIL t=%0t end_of_data expected %b got %b", t, want[28], got[28]);
    end
    if (got[28] && want[28])
    begin
        assert (got[27:16] == want[27:16]) else
        begin
            data_errs++;
            $display("FAIL t=%0t packet_len expected %0d got %0d", t, want[27:16], got[27:16]);
        end
    end
endtask

//////////////////////////////
// Compare process
//////////////////////////////
always @(negedge clk125)
begin
    if (!rst)
    begin
        assert (!conv_start || busy) else
        begin
            hs_errs++;
            $display("conv_start fired at %0t while busy was low", $time);
        end
        // Whole channel logged, turn it into expected events
        if (run_size > 0 && res_val.size() >= res_used + run_size)
        begin
            cur_chan = (n_chans > 1) ? `XADC_CHAN_W'(chans_built - run_base) :
                                       run_code[`XADC_CHAN_W-1:0];
            for (chk_idx = res_used; chk_idx < res_used + run_size; chk_idx++)
            begin
                assert (res_chan[chk_idx] == cur_chan) else
                begin
                    hs_errs++;
                    $display("FAIL t=%0t chan_sel expected %0d got %0d",
                             $time, cur_chan, res_chan[chk_idx]);
                end
            end
            build_expected(res_used, run_size, cur_chan);
            res_used    = res_used + run_size;
            chans_built = chans_built + 1;
        end
        if (fifo_wr || end_of_data)
        begin
            act_q.push_back({fifo_wr, end_of_data,
                             end_of_data ? packet_len : `XADC_LEN_W'(0),
                             fifo_wr ? fifo_data : `XADC_WORD_W'(0)});
            act_t.push_back($time);
            if (end_of_data)
                eod_seen++;
        end
        while (act_q.size() > 0 && exp_q.size() > 0)
            compare_event(act_q.pop_front(), exp_q.pop_front(), act_t.pop_front());
    end
end

// Worst case cycles for one run
function automatic int run_bound(input int code, input int size, input int gap);
    int chans;
    chans = (code > 7) ? 8 : 1;
    return chans * (size * (gap + 16) + 40) + 40;
endfunction

task automatic do_run(input int code, input int size, input int gap);
    int cyc;
    int bound;
    bound = run_bound(code, size, gap);
    @(posedge clk125);
    run_code    = 4'(code);
    run_size    = size;
    n_chans     = (code > 7) ? 8 : 1;
    run_base    = chans_built;
    chan_code   <= 4'(code);
    sample_size <= 11'(size);
    delay_in    <= 18'(gap);
    data_in_rdy <= 1'b1;
    cyc = 0;
    while (!busy && cyc < 4)                   // Request accept
    begin
        @(posedge clk125);
        cyc++;
    end
    assert (busy) else
    begin
        run_errs++;
        $display("busy did not rise after the request at %0t", $time);
    end
    cyc = 0;
    while (!(chans_built - run_base == n_chans && eod_seen == eod_expected) &&
           busy && cyc < bound)
    begin
        @(posedge clk125);
        cyc++;
    end
    assert (busy) else
    begin
        run_errs++;
        $display("busy fell at %0t before the request was withdrawn", $time);
    end
    assert (cyc < bound) else
    begin
        run_errs++;
        $display("Frames did not complete within %0d cycles", bound);
    end
    data_in_rdy <= 1'b0;                       // Release
    cyc = 0;
    while (busy && cyc < 8)
    begin
        @(posedge clk125);
        cyc++;
    end
    assert (!busy) else
    begin
        run_errs++;
        $display("busy stayed high after data_in_rdy dropped at %0t", $time);
    end
endtask

//////////////////////////////
// Main sequence
//////////////////////////////
initial
begin
    int t;
    rst         = 1'b1;
    data_in_rdy = 1'b0;
    chan_code   = '0;
    sample_size = '0;
    delay_in    = '0;
    repeat (16) @(posedge clk125);
    rst <= 1'b0;
    for (t = 0; t < test_size.size(); t++)
    begin
        $display("Test %0d: channel code %0d, %0d samples, gap %0d",
                 t + 1, test_code[t], test_size[t], test_gap[t]);
        do_run(test_code[t], test_size[t], test_gap[t]);
    end
    repeat (20) @(posedge clk125);             // Catch stray writes
    assert (act_q.size() == 0 && exp_q.size() == 0) else
    begin
        run_errs++;
        $display("%0d output events had no match, %0d expected events never appeared",
                 act_q.size(), exp_q.size());
    end
    $display("Errors: %0d data, %0d handshake, %0d run control", data_errs, hs_errs, run_errs);
    if (data_errs + hs_errs + run_errs == 0)
        $display("Simulation PASSED");
    else
        $display("Simulation FAILED");
    $finish;
end

// Watchdog sized from the run table
initial
begin
    int limit;
    int t;
    limit = 16 + 200;
    for (t = 0; t < test_size.size(); t++)
        limit = limit + run_bound(test_code[t], test_size[t], test_gap[t]) + 20;
    repeat (limit) @(posedge clk125);
    $display("Watchdog expired after %0d cycles, the run did not finish", limit);
    $display("Simulation FAILED");
    $finish;
end

endmodule

/* xadc_sampler.f */
+incdir+design
design/xadc_pkg.sv
design/sample_sequencer.sv
design/sample_delay_timer.sv
design/packet_assembler.sv
design/fifo_writer.sv
design/xadc_sampler_top.sv
test/tb_xadc_sampler.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f xadc_sampler.f \
    --top-module tb_xadc_sampler > sim.log 2>&1 &&
    ./obj_dir/Vtb_xadc_sampler >> sim.log 2>&1
grep -q "^Simulation PASSED$" sim.log && echo "PASS" && exit 0 ||
    { echo "FAIL, see sim.log"; exit 1; }
